/* hdl/icache_cfg_pkg.sv */
package icache_cfg_pkg;

    // ============================================================
    // Bus and line widths
    // ============================================================

    // Fetch address and instruction word width
    localparam int XLEN = 64;

    // One cache line as delivered by the memory port
    localparam int LINE_BITS = 128;

    // ============================================================
    // Associativity
    // ============================================================

    localparam int N_WAYS = 4;
    localparam int WAY_BITS = 2;

    // ============================================================
    // Address fields
    // ============================================================

    // Byte offset inside one word
    localparam int BYTE_BITS = 3;
    // Word offset inside one line
    localparam int WORD_BITS = 1;
    // Low edge of the set index
    localparam int OFFSET_BITS = BYTE_BITS + WORD_BITS;

    // Word 0 of a line (lower address) sits in bits 127..64

endpackage

/* hdl/icache_ctrl.sv */
module icache_ctrl
#(
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = icache_cfg_pkg::XLEN - IDX_W - icache_cfg_pkg::OFFSET_BITS
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 p_strobe_i,
    input  logic [icache_cfg_pkg::XLEN-1:0]      p_addr_i,
    output logic [icache_cfg_pkg::XLEN-1:0]      p_data_o,
    output logic                                 p_ready_o,
    output logic                                 m_strobe_o,
    output logic [icache_cfg_pkg::XLEN-1:0]      m_addr_o,
    input  logic [icache_cfg_pkg::LINE_BITS-1:0] m_data_i,
    input  logic                                 m_ready_i,
    input  logic                                 hit_i,
    input  logic [icache_cfg_pkg::LINE_BITS-1:0] hit_line_i,
    output logic [IDX_W-1:0]                     rd_index_o,
    output logic [IDX_W-1:0]                     set_index_o,
    output logic                                 fill_o,
    output logic [TAG_W-1:0]                     fill_tag_o,
    output logic                                 clear_o,
    output logic [IDX_W-1:0]                     clear_index_o
);

    localparam int XLEN = icache_cfg_pkg::XLEN;
    localparam int LINE_BITS = icache_cfg_pkg::LINE_BITS;
    localparam int OFF = icache_cfg_pkg::OFFSET_BITS;
    localparam int WORD_BITS = icache_cfg_pkg::WORD_BITS;
    localparam int N_WORDS = 2 ** WORD_BITS;

    icache_ctrl_pkg::icache_state_e state_q;
    icache_ctrl_pkg::icache_state_e state_d;

    logic [IDX_W-1:0]     clr_cnt_q;
    // Latched request address
    logic [XLEN-1:0]      addr_q;
    logic [WORD_BITS-1:0] word_off;

    // Lower word index maps to the upper part of the line
    function automatic logic [XLEN-1:0] pick_word(input logic [LINE_BITS-1:0] line,
                                                  input logic [WORD_BITS-1:0] off);
        return line[(N_WORDS - 1 - int'(off)) * XLEN +: XLEN];
    endfunction

    // ============================================================
    // FSM
    // ============================================================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= icache_ctrl_pkg::ST_INIT;
            clr_cnt_q <= '0;
        end
        else
        begin
            state_q <= state_d;
            // Walk every set once during the clear pass
            if (state_q == icache_ctrl_pkg::ST_INIT)
                clr_cnt_q <= clr_cnt_q + 1'b1;
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_ctrl_pkg::ST_INIT:
                if (clr_cnt_q == IDX_W'(N_SETS - 1))
                    state_d = icache_ctrl_pkg::ST_IDLE;
            icache_ctrl_pkg::ST_IDLE:
                if (p_strobe_i)
                    state_d = icache_ctrl_pkg::ST_LOOKUP;
            icache_ctrl_pkg::ST_LOOKUP:
                // Hit returns to idle, miss fetches the line
                state_d = hit_i ? icache_ctrl_pkg::ST_IDLE : icache_ctrl_pkg::ST_MISS_REQ;
            icache_ctrl_pkg::ST_MISS_REQ:
                state_d = icache_ctrl_pkg::ST_MISS_WAIT;
            icache_ctrl_pkg::ST_MISS_WAIT:
                if (m_ready_i)
                    state_d = icache_ctrl_pkg::ST_IDLE;
            default:
                state_d = icache_ctrl_pkg::ST_IDLE;
        endcase
    end

    // Request is captured when accepted in idle
    always_ff @(posedge clk_i)
    begin
        if (state_q == icache_ctrl_pkg::ST_IDLE && p_strobe_i)
            addr_q <= p_addr_i;
    end

    // ============================================================
    // Memory request
    // ============================================================

    // One strobe cycle right after ST_MISS_REQ, address zero otherwise
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            m_addr_o <= '0;
        end
        else if (state_q == icache_ctrl_pkg::ST_MISS_REQ)
        begin
            m_strobe_o <= 1'b1;
            m_addr_o <= {addr_q[XLEN-1:OFF], {OFF{1'b0}}};
        end
        else
        begin
            m_strobe_o <= 1'b0;
            m_addr_o <= '0;
        end
    end

    // ============================================================
    // Array control and fetch response
    // ============================================================

    // Data RAM read starts in the accept cycle
    assign rd_index_o = (state_q == icache_ctrl_pkg::ST_IDLE) ? p_addr_i[OFF +: IDX_W]
                                                             : addr_q[OFF +: IDX_W];
    assign set_index_o = addr_q[OFF +: IDX_W];
    assign fill_tag_o = addr_q[XLEN-1 -: TAG_W];
    assign fill_o = (state_q == icache_ctrl_pkg::ST_MISS_WAIT) && m_ready_i;
    assign clear_o = (state_q == icache_ctrl_pkg::ST_INIT);
    assign clear_index_o = clr_cnt_q;

    assign word_off = addr_q[icache_cfg_pkg::BYTE_BITS +: WORD_BITS];
    // Hit answers in lookup, miss answers with the incoming line
    assign p_ready_o = ((state_q == icache_ctrl_pkg::ST_LOOKUP) && hit_i) || fill_o;
    assign p_data_o = pick_word((state_q == icache_ctrl_pkg::ST_LOOKUP) ? hit_line_i
                                                                      : m_data_i, word_off);

    // Single-cycle memory strobe
    a_strobe_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        m_strobe_o |=> !m_strobe_o)
        else $error("m_strobe_o high for two cycles");

    // No fetch answer or memory traffic during the clear pass
    a_init_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == icache_ctrl_pkg::ST_INIT) |-> !p_ready_o && !m_strobe_o)
        else $error("activity during valid clear");

endmodule

/* hdl/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // ============================================================
    // Controller FSM states
    // ============================================================

    typedef enum logic [2:0]
    {
        // Valid-bit clear pass after reset
        ST_INIT,
        // Waiting for a fetch strobe
        ST_IDLE,
        // Tag compare on the latched request
        ST_LOOKUP,
        // Issue the line request
        ST_MISS_REQ,
        // Wait for the line from memory
        ST_MISS_WAIT
    } icache_state_e;

endpackage

/* hdl/icache_top.sv */
module icache_top
#(
    parameter int N_SETS = 16
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 p_strobe_i,
    input  logic [icache_cfg_pkg::XLEN-1:0]      p_addr_i,
    output logic [icache_cfg_pkg::XLEN-1:0]      p_data_o,
    output logic                                 p_ready_o,
    output logic                                 m_strobe_o,
    output logic [icache_cfg_pkg::XLEN-1:0]      m_addr_o,
    input  logic [icache_cfg_pkg::LINE_BITS-1:0] m_data_i,
    input  logic                                 m_ready_i
);

    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = icache_cfg_pkg::XLEN - IDX_W - icache_cfg_pkg::OFFSET_BITS;

    // ============================================================
    // Internal wiring
    // ============================================================

    logic [IDX_W-1:0]                     rd_index;
    logic [IDX_W-1:0]                     set_index;
    logic                                 fill;
    logic [TAG_W-1:0]                     fill_tag;
    logic                                 clear;
    logic [IDX_W-1:0]                     clear_index;
    logic                                 hit;
    logic [icache_cfg_pkg::LINE_BITS-1:0] hit_line;
    logic [icache_cfg_pkg::WAY_BITS-1:0]  victim;

    icache_ctrl #(.N_SETS(N_SETS)) u_ctrl
    (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .p_strobe_i(p_strobe_i),
        .p_addr_i(p_addr_i),
        .p_data_o(p_data_o),
        .p_ready_o(p_ready_o),
        .m_strobe_o(m_strobe_o),
        .m_addr_o(m_addr_o),
        .m_data_i(m_data_i),
        .m_ready_i(m_ready_i),
        .hit_i(hit),
        .hit_line_i(hit_line),
        .rd_index_o(rd_index),
        .set_index_o(set_index),
        .fill_o(fill),
        .fill_tag_o(fill_tag),
        .clear_o(clear),
        .clear_index_o(clear_index)
    );

    // Fill data comes straight from the memory port
    icache_way_array #(.N_SETS(N_SETS)) u_ways
    (
        .clk_i(clk_i),
        .rd_index_i(rd_index),
        .set_index_i(set_index),
        .fill_i(fill),
        .fill_tag_i(fill_tag),
        .fill_line_i(m_data_i),
        .victim_i(victim),
        .clear_i(clear),
        .clear_index_i(clear_index),
        .hit_o(hit),
        .hit_line_o(hit_line)
    );

    // Each fill advances the FIFO pointer of its set
    icache_victim_sel #(.N_SETS(N_SETS)) u_victim
    (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .set_index_i(set_index),
        .advance_i(fill),
        .victim_o(victim)
    );

endmodule

/* hdl/icache_victim_sel.sv */
module icache_victim_sel
#(
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS)
)
(
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [IDX_W-1:0]                    set_index_i,
    input  logic                                advance_i,
    output logic [icache_cfg_pkg::WAY_BITS-1:0] victim_o
);

    // One round-robin pointer per set
    logic [icache_cfg_pkg::WAY_BITS-1:0] fifo_cnt [N_SETS];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < N_SETS; s++)
                fifo_cnt[s] <= '0;
        end
        else if (advance_i)
        begin
            // Wraps from the last way back to way 0
            fifo_cnt[set_index_i] <= fifo_cnt[set_index_i] + 1'b1;
        end
    end

    // Oldest way of the current set
    assign victim_o = fifo_cnt[set_index_i];

endmodule

/* hdl/icache_way_array.sv */
module icache_way_array
#(
    parameter int N_SETS = 16,
    localparam int IDX_W = $clog2(N_SETS),
    localparam int TAG_W = icache_cfg_pkg::XLEN - IDX_W - icache_cfg_pkg::OFFSET_BITS
)
(
    input  logic                                 clk_i,
    input  logic [IDX_W-1:0]                     rd_index_i,
    input  logic [IDX_W-1:0]                     set_index_i,
    input  logic                                 fill_i,
    input  logic [TAG_W-1:0]                     fill_tag_i,
    input  logic [icache_cfg_pkg::LINE_BITS-1:0] fill_line_i,
    input  logic [icache_cfg_pkg::WAY_BITS-1:0]  victim_i,
    input  logic                                 clear_i,
    input  logic [IDX_W-1:0]                     clear_index_i,
    output logic                                 hit_o,
    output logic [icache_cfg_pkg::LINE_BITS-1:0] hit_line_o
);

    localparam int N_WAYS = icache_cfg_pkg::N_WAYS;
    localparam int LINE_BITS = icache_cfg_pkg::LINE_BITS;

    logic [N_WAYS-1:0]    way_hit;
    logic [LINE_BITS-1:0] way_line [N_WAYS];

    // ============================================================
    // Per-way storage
    // ============================================================

    for (genvar w = 0; w < N_WAYS; w++)
    begin : g_way
        logic [LINE_BITS-1:0] data_mem [N_SETS];
        logic [TAG_W-1:0]     tag_mem [N_SETS];
        logic                 valid_mem [N_SETS];
        logic [LINE_BITS-1:0] rd_line_q;
        logic                 we;

        // Only the victim way takes the fill
        assign we = fill_i && (victim_i == icache_cfg_pkg::WAY_BITS'(w));

        // Data RAM, synchronous read, write-first
        always_ff @(posedge clk_i)
        begin
            if (we)
                data_mem[set_index_i] <= fill_line_i;
            if (we && (rd_index_i == set_index_i))
                rd_line_q <= fill_line_i;
            else
                rd_line_q <= data_mem[rd_index_i];
        end

        // Tag RAM, asynchronous read
        always_ff @(posedge clk_i)
        begin
            if (we)
                tag_mem[set_index_i] <= fill_tag_i;
        end

        // Valid bits, clear pass has priority over fills
        always_ff @(posedge clk_i)
        begin
            if (clear_i)
                valid_mem[clear_index_i] <= 1'b0;
            else if (we)
                valid_mem[set_index_i] <= 1'b1;
        end

        assign way_line[w] = rd_line_q;
        // Compare against the tag of the latched request
        assign way_hit[w] = valid_mem[set_index_i] && (tag_mem[set_index_i] == fill_tag_i);
    end

    // ============================================================
    // Hit detection and line select
    // ============================================================

    assign hit_o = |way_hit;

    always_comb
    begin
        hit_line_o = '0;
        for (int w = 0; w < N_WAYS; w++)
        begin
            if (way_hit[w])
                hit_line_o = way_line[w];
        end
    end

    // Freshly filled line is found in exactly one way on the next cycle
    a_one_way_hit: assert property (@(posedge clk_i)
        fill_i |=> $onehot(way_hit))
        else $error("filled tag not found in exactly one way");

endmodule

/* run.sh */
#!/bin/sh
# Builds and runs the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module icache_tb -f tb.f -o icache_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/icache_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" sim.log; then
    echo "result: pass"
    exit 0
fi

echo "result: fail"
exit 1

/* sim/icache_tb.sv */
module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_SETS = 16;
    localparam int XLEN = icache_cfg_pkg::XLEN;
    localparam int OFF = icache_cfg_pkg::OFFSET_BITS;
    localparam int IDX_W = $clog2(N_SETS);
    localparam int TAG_W = XLEN - IDX_W - OFF;
    localparam logic [XLEN-1:0] PAT = 64'hA5A5_0000_5A5A_0000;
    localparam int N_DIRECTED = 15;
    localparam int N_RANDOM = 300;
    // Directed fetches plus the random mix at 40 cycles each
    localparam int MAX_CYCLES = 40 * (N_DIRECTED + N_RANDOM) + 200;

    logic                                 clk_i;
    logic                                 rst_i;
    logic                                 p_strobe_i;
    logic [XLEN-1:0]                      p_addr_i;
    logic [XLEN-1:0]                      p_data_o;
    logic                                 p_ready_o;
    logic                                 m_strobe_o;
    logic [XLEN-1:0]                      m_addr_o;
    logic [icache_cfg_pkg::LINE_BITS-1:0] m_data_i;
    logic                                 m_ready_i;
    int                                   mem_strobes;
    int                                   mem_overlaps;

    // Reference model state per set
    logic [TAG_W-1:0] tag_m [N_SETS][4];
    logic             valid_m [N_SETS][4];
    int               fifo_m [N_SETS];
    int               model_misses;

    int pass_cnt;
    int fail_cnt;
    int cycles = 0;
    int seed;

    icache_top #(.N_SETS(N_SETS)) dut
    (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .p_strobe_i(p_strobe_i),
        .p_addr_i(p_addr_i),
        .p_data_o(p_data_o),
        .p_ready_o(p_ready_o),
        .m_strobe_o(m_strobe_o),
        .m_addr_o(m_addr_o),
        .m_data_i(m_data_i),
        .m_ready_i(m_ready_i)
    );

    tb_mem_responder #(.SEED(32'h2d33)) u_mem
    (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .m_strobe_i(m_strobe_o),
        .m_addr_i(m_addr_o),
        .m_data_o(m_data_i),
        .m_ready_o(m_ready_i),
        .strobe_cnt_o(mem_strobes),
        .overlap_cnt_o(mem_overlaps)
    );

    // ============================================================
    // Clock and run limit
    // ============================================================

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ============================================================
    // Checking helpers
    // ============================================================

    task automatic compare_value(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
        if (exp !== act)
        begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_cnt++;
        end
        else
            pass_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        fail_cnt++;
    endtask

    task automatic finish_test(input string name, input int fails_before);
        $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
    endtask

    // Word containing byte address a per the memory fill rule
    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] a);
        return {a[XLEN-1:3], 3'b000} ^ PAT;
    endfunction

    function automatic logic [XLEN-1:0] make_addr(input logic [TAG_W-1:0] tag, input int s,
                                                  input int word);
        return {tag, IDX_W'(s), word[0], 3'b000};
    endfunction

    // Predicts hit or miss and updates tags and FIFO pointer on a miss
    function automatic logic model_access(input logic [XLEN-1:0] addr);
        int s;
        logic [TAG_W-1:0] tag;
        logic hit;
        s = int'(addr[OFF +: IDX_W]);
        tag = addr[XLEN-1 -: TAG_W];
        hit = 1'b0;
        for (int w = 0; w < 4; w++)
        begin
            if (valid_m[s][w] && tag_m[s][w] == tag)
                hit = 1'b1;
        end
        // Oldest way of the set takes the line
        if (!hit)
        begin
            tag_m[s][fifo_m[s]] = tag;
            valid_m[s][fifo_m[s]] = 1'b1;
            fifo_m[s] = (fifo_m[s] + 1) % 4;
            model_misses++;
        end
        return hit;
    endfunction

    // One fetch with its word, latency and memory traffic checked
    task automatic run_fetch(input logic [XLEN-1:0] addr);
        logic exp_hit;
        int strobes_before;
        int lat;
        exp_hit = model_access(addr);
        strobes_before = mem_strobes;
        @(posedge clk_i);
        p_strobe_i <= 1'b1;
        p_addr_i <= addr;
        lat = 0;
        do
        begin
            @(negedge clk_i);
            lat++;
            if (m_strobe_o)
                compare_value("m_addr_o", {addr[XLEN-1:OFF], {OFF{1'b0}}}, m_addr_o);
        end
        while (!p_ready_o);
        compare_value("p_data_o", word_at(addr), p_data_o);
        // Accepted at the first edge and answered in the following cycle
        if (exp_hit)
            compare_value("hit latency", 2, lat);
        else if (!m_ready_i)
            report_failure("p_ready_o answered a miss without m_ready_i");
        compare_value("m_strobe_o count", exp_hit ? 0 : 1, mem_strobes - strobes_before);
        @(posedge clk_i);
        p_strobe_i <= 1'b0;
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        int fails_at;
        logic [XLEN-1:0] a0;
        logic [XLEN-1:0] a1;
        logic [31:0] r;
        logic [TAG_W-1:0] ft [6];
        logic [TAG_W-1:0] tag_pool [6];
        seed = 32'h2d33;
        rst_i = 1'b1;
        p_strobe_i = 1'b0;
        p_addr_i = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        model_misses = 0;
        for (int s = 0; s < N_SETS; s++)
        begin
            fifo_m[s] = 0;
            for (int w = 0; w < 4; w++)
                valid_m[s][w] = 1'b0;
        end
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;

        // Valid clear pass keeps both ports quiet
        fails_at = fail_cnt;
        repeat (N_SETS)
        begin
            @(negedge clk_i);
            compare_value("p_ready_o", 0, p_ready_o);
            compare_value("m_strobe_o", 0, m_strobe_o);
            compare_value("m_addr_o", 0, m_addr_o);
        end
        finish_test("reset", fails_at);
        repeat (2) @(posedge clk_i);

        // Cold misses on word 0 and word 1
        fails_at = fail_cnt;
        a0 = make_addr(TAG_W'(56'h12_3456), 2, 0);
        a1 = make_addr(TAG_W'(56'h9_abcd), 3, 1);
        run_fetch(a0);
        run_fetch(a1);
        finish_test("cold_miss", fails_at);

        // Other word of each filled line
        fails_at = fail_cnt;
        run_fetch(a0 + 64'd8);
        run_fetch(a1 - 64'd8);
        finish_test("hit", fails_at);

        // Five tags into set 5 so the fifth evicts the first
        fails_at = fail_cnt;
        for (int i = 0; i < 6; i++)
            ft[i] = TAG_W'(32'h100 + i);
        for (int i = 0; i < 5; i++)
            run_fetch(make_addr(ft[i], 5, i % 2));
        run_fetch(make_addr(ft[0], 5, 0));
        for (int i = 2; i < 5; i++)
            run_fetch(make_addr(ft[i], 5, 1));
        // Sixth tag takes the next FIFO slot and the displaced tag then misses
        run_fetch(make_addr(ft[5], 5, 0));
        run_fetch(make_addr(ft[2], 5, 0));
        finish_test("fifo_eviction", fails_at);

        // Small tag pool spread over all sets
        fails_at = fail_cnt;
        for (int i = 0; i < 6; i++)
            tag_pool[i] = TAG_W'({$random(seed), $random(seed)});
        for (int n = 0; n < N_RANDOM; n++)
        begin
            r = $random(seed);
            run_fetch({tag_pool[$unsigned($random(seed)) % 6], r[OFF+IDX_W-1:0]});
        end
        compare_value("total m_strobe_o count", model_misses, mem_strobes);
        if (mem_overlaps != 0)
            report_failure("memory saw a second strobe while a request was pending");
        finish_test("random_mix", fails_at);

        $display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* sim/tb_mem_responder.sv */
module tb_mem_responder
#(
    parameter int SEED = 32'h2d33
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 m_strobe_i,
    input  logic [icache_cfg_pkg::XLEN-1:0]      m_addr_i,
    output logic [icache_cfg_pkg::LINE_BITS-1:0] m_data_o,
    output logic                                 m_ready_o,
    output int                                   strobe_cnt_o,
    output int                                   overlap_cnt_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Word at byte address A holds A xor this pattern
    localparam logic [63:0] PAT = 64'hA5A5_0000_5A5A_0000;

    initial
    begin
        int seed;
        int delay;
        logic pending;
        logic [63:0] addr_q;
        seed = SEED;
        delay = 0;
        pending = 1'b0;
        addr_q = '0;
        m_data_o = '0;
        m_ready_o = 1'b0;
        strobe_cnt_o = 0;
        overlap_cnt_o = 0;
        forever
        begin
            @(posedge clk_i);
            // Ready is a single-cycle pulse
            m_ready_o <= 1'b0;
            if (rst_i)
                pending = 1'b0;
            else if (m_strobe_i)
            begin
                strobe_cnt_o <= strobe_cnt_o + 1;
                // Only one request may be outstanding
                if (pending)
                    overlap_cnt_o <= overlap_cnt_o + 1;
                pending = 1'b1;
                addr_q = m_addr_i;
                delay = 1 + int'($unsigned($random(seed)) % 6);
            end
            else if (pending)
            begin
                delay = delay - 1;
                if (delay == 0)
                begin
                    m_ready_o <= 1'b1;
                    // Lower-addressed word goes in the upper half
                    m_data_o <= {addr_q ^ PAT, (addr_q + 64'd8) ^ PAT};
                    pending = 1'b0;
                end
            end
        end
    end

endmodule

/* tb.f */
hdl/icache_cfg_pkg.sv
hdl/icache_ctrl_pkg.sv
hdl/icache_ctrl.sv
hdl/icache_way_array.sv
hdl/icache_victim_sel.sv
hdl/icache_top.sv
sim/tb_mem_responder.sv
sim/icache_tb.sv
